/* dither_spi.f */
src/dither_pkg.sv
src/frame_buffer.sv
src/spi_byte_port.sv
src/dither_sequencer.sv
src/error_diffuser.sv
src/dither_top.sv
testbench/dither_checker.sv
testbench/tb_dither_top.sv

/* Bender.yml */
package:
  name: dither_spi

sources:
  - src/dither_pkg.sv
  - src/frame_buffer.sv
  - src/spi_byte_port.sv
  - src/dither_sequencer.sv
  - src/error_diffuser.sv
  - src/dither_top.sv
  - target: test
    files:
      - testbench/dither_checker.sv
      - testbench/tb_dither_top.sv

/* testbench/tb_dither_top.sv */
//########################################
// halftoning engine testbench
// loads frames over SPI, checks readback
//########################################
`timescale 1ns/100ps

module tb_dither_top import dither_pkg::*; ();

    localparam int         N_TESTS     = 5;
    localparam int         WAIT_LIMIT  = 2000;
    localparam int         PULSE_BYTES = 4;
    localparam int         FLAG_BUSY   = 0;
    localparam int         FLAG_READY  = 1;
    localparam logic [1:0] KIND_FILL   = 2'd0;
    localparam logic [1:0] KIND_RAMP   = 2'd1;
    localparam logic [1:0] KIND_RANDOM = 2'd2;

    // one row of the test table
    typedef struct packed {
        logic [1:0] kind;
        logic       cs_pulse;
        pixel_t     fill;
    } test_row_t;

    logic                   SPI_CLK;
    logic                   rst;
    logic                   spi_cs;
    logic                   spi_mosi;
    logic                   spi_miso;
    logic                   busy;
    logic                   frame_ready;
    pixel_t                 image [PIX_N];
    int                     work [PIX_N];
    logic [PIX_N*PIX_W-1:0] exp_frame;
    test_row_t              test_tbl [N_TESTS];
    int                     test_id;
    logic                   report;
    int                     error_count;
    int                     tests_done;

    dither_top i_dut (
        .SPI_CLK     (SPI_CLK),
        .rst         (rst),
        .spi_cs      (spi_cs),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .busy        (busy),
        .frame_ready (frame_ready)
    );

    dither_checker i_checker (
        .SPI_CLK     (SPI_CLK),
        .rst         (rst),
        .spi_cs      (spi_cs),
        .spi_miso    (spi_miso),
        .busy        (busy),
        .frame_ready (frame_ready),
        .exp_frame   (exp_frame),
        .test_id     (test_id),
        .report      (report),
        .error_count (error_count),
        .tests_done  (tests_done)
    );

    always #20 SPI_CLK = ~SPI_CLK;

    // floor of x/16 toward minus infinity
    function automatic int floor_div16(input int x);
        if (x >= 0) return x / 16;
        return -((-x + 15) / 16);
    endfunction

    function automatic logic flag_value(input int which);
        return (which == FLAG_BUSY) ? busy : frame_ready;
    endfunction

    // neighbor gets weighted error clamped to the pixel range
    task automatic add_error(input int n, input int err, input int w);
        int v;
        v = work[n] + floor_div16(err * w);
        if (v < 0) v = 0;
        if (v > PIX_MAX) v = PIX_MAX;
        work[n] = v;
    endtask

    // reference floyd-steinberg pass in raster order
    task automatic compute_expected();
        int p;
        int old_v;
        int new_v;
        int err;
        for (p = 0; p < PIX_N; p++) begin
            work[p] = image[p];
        end
        for (p = 0; p < PIX_N; p++) begin
            old_v   = work[p];
            new_v   = (old_v >= THRESHOLD) ? PIX_MAX : 0;
            work[p] = new_v;
            err     = old_v - new_v;
            if (p % IMG_W != IMG_W - 1) add_error(p + 1, err, W_EAST);
            if (p / IMG_W != IMG_H - 1) begin
                if (p % IMG_W != 0) add_error(p + IMG_W - 1, err, W_SOUTHWEST);
                add_error(p + IMG_W, err, W_SOUTH);
                if (p % IMG_W != IMG_W - 1) add_error(p + IMG_W + 1, err, W_SOUTHEAST);
            end
        end
        for (p = 0; p < PIX_N; p++) begin
            exp_frame[p*PIX_W +: PIX_W] = pixel_t'(work[p]);
        end
    endtask

    task automatic build_image(input test_row_t row);
        int p;
        for (p = 0; p < PIX_N; p++) begin
            case (row.kind)
                KIND_RAMP:   image[p] = pixel_t'(((p % IMG_W) * PIX_MAX) / (IMG_W - 1));
                KIND_RANDOM: image[p] = pixel_t'($urandom);
                default:     image[p] = row.fill;
            endcase
        end
    endtask

    // one mode 0 byte with cs low for 8 bits then high for a cycle
    task automatic shift_byte(input pixel_t tx);
        int b;
        @(posedge SPI_CLK);
        spi_cs   <= 1'b0;
        spi_mosi <= tx[PIX_W-1];
        for (b = PIX_W - 2; b >= 0; b--) begin
            @(posedge SPI_CLK);
            spi_mosi <= tx[b];
        end
        @(posedge SPI_CLK);
        spi_cs   <= 1'b1;
        spi_mosi <= 1'b0;
    endtask

    task automatic wait_flag(input int which, input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge SPI_CLK);
        while (flag_value(which) !== level && cycles < WAIT_LIMIT) begin
            @(negedge SPI_CLK);
            cycles++;
        end
        if (flag_value(which) !== level) begin
            $display("timeout: %s did not happen within %0d cycles in test %0d",
                     what, WAIT_LIMIT, test_id);
            $display("Simulation finished: FAIL");
            $finish;
        end
    endtask

    initial begin
        int t;
        int p;
        SPI_CLK   = 1'b0;
        rst       = 1'b1;
        spi_cs    = 1'b1;
        spi_mosi  = 1'b0;
        report    = 1'b0;
        test_id   = 0;
        exp_frame = '0;
        void'($urandom(32'h749e7047));
        // kind, cs pulses during the pass, fill value
        test_tbl[0] = {KIND_FILL, 1'b0, 8'd0};
        test_tbl[1] = {KIND_FILL, 1'b1, 8'd200};
        test_tbl[2] = {KIND_FILL, 1'b0, 8'd127};
        test_tbl[3] = {KIND_RAMP, 1'b1, 8'd0};
        test_tbl[4] = {KIND_RANDOM, 1'b1, 8'd0};
        repeat (8) @(posedge SPI_CLK);
        rst <= 1'b0;
        for (t = 0; t < N_TESTS; t++) begin
            test_id = t;
            build_image(test_tbl[t]);
            compute_expected();
            for (p = 0; p < PIX_N; p++) begin
                shift_byte(image[p]);
            end
            wait_flag(FLAG_BUSY, 1'b1, "busy rising after load");
            // traffic the engine must ignore
            if (test_tbl[t].cs_pulse) begin
                for (p = 0; p < PULSE_BYTES; p++) begin
                    shift_byte(pixel_t'($urandom));
                end
            end
            wait_flag(FLAG_READY, 1'b1, "frame_ready rising after the pass");
            repeat (4) @(posedge SPI_CLK);
            for (p = 0; p < PIX_N; p++) begin
                shift_byte(8'h00);
            end
            wait_flag(FLAG_READY, 1'b0, "frame_ready falling after readback");
        end
        repeat (2) @(posedge SPI_CLK);
        report <= 1'b1;
        @(negedge SPI_CLK);
        if (error_count == 0 && tests_done == N_TESTS) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/dither_checker.sv */
//########################################
// halftoning engine response checker
// readback bytes and busy/ready flags
//########################################
`timescale 1ns/100ps

module dither_checker import dither_pkg::*; (
    input  logic                   SPI_CLK,
    input  logic                   rst,
    input  logic                   spi_cs,
    input  logic                   spi_miso,
    input  logic                   busy,
    input  logic                   frame_ready,
    input  logic [PIX_N*PIX_W-1:0] exp_frame,
    input  int                     test_id,
    input  logic                   report,
    output int                     error_count,
    output int                     tests_done
);

    // read step, then 5 steps per pixel
    localparam int PASS_CYCLES = 1 + 5 * PIX_N;

    pixel_t rx_byte      = '0;
    int     bit_n        = 0;
    int     byte_n       = 0;
    int     busy_cycles  = 0;
    int     test_errs    = 0;
    int     tests_passed = 0;
    logic   rst_q        = 1'b1;
    logic   busy_q       = 1'b0;

    initial begin
        error_count = 0;
        tests_done  = 0;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp_v, got_v);
        error_count = error_count + 1;
        test_errs   = test_errs + 1;
    endtask

    // falling edge, all DUT outputs settled
    always @(negedge SPI_CLK) begin
        // idle outputs right after reset release
        if (rst_q && !rst) begin
            if (busy !== 1'b0) report_mismatch("busy", 0, busy);
            if (frame_ready !== 1'b0) report_mismatch("frame_ready", 0, frame_ready);
            if (spi_miso !== 1'b0) report_mismatch("spi_miso", 0, spi_miso);
        end
        rst_q = rst;
        if (!rst) begin
            if (busy === 1'b1) begin
                busy_cycles = busy_cycles + 1;
            end
            // end of pass, ready must rise with busy falling
            if (busy_q && busy !== 1'b1) begin
                if (frame_ready !== 1'b1) report_mismatch("frame_ready", 1, frame_ready);
                if (busy_cycles != PASS_CYCLES) begin
                    report_mismatch("busy cycles", PASS_CYCLES, busy_cycles);
                end
                busy_cycles = 0;
            end
            busy_q = (busy === 1'b1);
            // bit slot of the readback, msb first
            if (frame_ready === 1'b1 && spi_cs === 1'b0) begin
                rx_byte = {rx_byte[PIX_W-2:0], spi_miso};
                bit_n   = bit_n + 1;
                if (bit_n == PIX_W) begin
                    if (rx_byte !== exp_frame[byte_n*PIX_W +: PIX_W]) begin
                        report_mismatch($sformatf("spi_miso byte %0d", byte_n),
                                        exp_frame[byte_n*PIX_W +: PIX_W], rx_byte);
                    end
                    bit_n  = 0;
                    byte_n = byte_n + 1;
                end
                // whole frame read back
                if (byte_n == PIX_N) begin
                    if (test_errs == 0) begin
                        $display("test %0d: %0d bytes ok", test_id, PIX_N);
                        tests_passed = tests_passed + 1;
                    end else begin
                        $display("test %0d: %0d errors", test_id, test_errs);
                    end
                    tests_done = tests_done + 1;
                    test_errs  = 0;
                    byte_n     = 0;
                end
            end
        end
    end

    always @(posedge report) begin
        $display("checker: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_done, tests_passed, tests_done - tests_passed, error_count);
    end

endmodule

/* src/dither_top.sv */
//########################################
// 8x8 halftoning engine top level
// SPI in, one diffusion pass, SPI out
//########################################
`timescale 1ns/100ps

module dither_top import dither_pkg::*; (
    input  logic SPI_CLK,
    input  logic rst,
    input  logic spi_cs,
    input  logic spi_mosi,
    output logic spi_miso,
    output logic busy,
    output logic frame_ready
);

    mode_t  mode;
    step_t  step;

    // SPI side of port A
    addr_t  spi_addr;
    pixel_t spi_wdata;
    logic   spi_we;
    logic   load_done;
    logic   unload_done;

    // engine side
    addr_t  eng_addr_a;
    pixel_t eng_wdata_a;
    logic   eng_we_a;
    addr_t  addr_b;

    pixel_t q_a;
    pixel_t q_b;

    frame_buffer i_frame_buffer (
        .SPI_CLK     (SPI_CLK),
        .mode        (mode),
        .spi_addr    (spi_addr),
        .spi_wdata   (spi_wdata),
        .spi_we      (spi_we),
        .eng_addr_a  (eng_addr_a),
        .eng_wdata_a (eng_wdata_a),
        .eng_we_a    (eng_we_a),
        .addr_b      (addr_b),
        .q_a         (q_a),
        .q_b         (q_b)
    );

    spi_byte_port i_spi_byte_port (
        .SPI_CLK     (SPI_CLK),
        .rst         (rst),
        .spi_cs      (spi_cs),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .mode        (mode),
        .q_a         (q_a),
        .spi_addr    (spi_addr),
        .spi_wdata   (spi_wdata),
        .spi_we      (spi_we),
        .load_done   (load_done),
        .unload_done (unload_done)
    );

    dither_sequencer i_dither_sequencer (
        .SPI_CLK     (SPI_CLK),
        .rst         (rst),
        .load_done   (load_done),
        .unload_done (unload_done),
        .mode        (mode),
        .step        (step),
        .busy        (busy),
        .frame_ready (frame_ready),
        .eng_addr_a  (eng_addr_a),
        .eng_we_a    (eng_we_a),
        .addr_b      (addr_b)
    );

    error_diffuser i_error_diffuser (
        .SPI_CLK     (SPI_CLK),
        .rst         (rst),
        .step        (step),
        .q_b         (q_b),
        .eng_wdata_a (eng_wdata_a)
    );

endmodule

/* src/error_diffuser.sv */
//########################################
// threshold and error diffusion datapath
//########################################
`timescale 1ns/100ps

module error_diffuser import dither_pkg::*; (
    input  logic   SPI_CLK,
    input  logic   rst,
    input  step_t  step,
    input  pixel_t q_b,
    output pixel_t eng_wdata_a
);

    pixel_t             new_pix;
    qerr_t              err_d;
    qerr_t              err_q;
    logic signed [4:0]  weight;
    logic signed [13:0] prod;
    logic signed [13:0] sum;
    pixel_t             sat;

    // black or white
    assign new_pix = (q_b >= THRESHOLD) ? pixel_t'(PIX_MAX) : '0;
    assign err_d   = $signed({1'b0, q_b}) - $signed({1'b0, new_pix});

    // quantization error of the current pixel
    always_ff @(posedge SPI_CLK or posedge rst) begin
        if (rst) begin
            err_q <= '0;
        end else if (step == STEP_QUANTIZE) begin
            err_q <= err_d;
        end
    end

    always_comb begin
        case (step)
            STEP_EAST:      weight = 5'(W_EAST);
            STEP_SOUTHWEST: weight = 5'(W_SOUTHWEST);
            STEP_SOUTH:     weight = 5'(W_SOUTH);
            STEP_SOUTHEAST: weight = 5'(W_SOUTHEAST);
            default:        weight = '0;
        endcase
    end

    // err*w/16, arithmetic shift floors toward minus infinity
    assign prod = err_q * weight;
    assign sum  = $signed({6'b0, q_b}) + (prod >>> 4);

    // clamp to 0..255
    always_comb begin
        if (sum < 0) begin
            sat = '0;
        end else if (sum > PIX_MAX) begin
            sat = pixel_t'(PIX_MAX);
        end else begin
            sat = sum[PIX_W-1:0];
        end
    end

    assign eng_wdata_a = (step == STEP_QUANTIZE) ? new_pix : sat;

endmodule

/* src/dither_sequencer.sv */
//########################################
// mode FSM and per-pixel step schedule
// drives engine addresses and write enable
//########################################
`timescale 1ns/100ps

module dither_sequencer import dither_pkg::*; (
    input  logic  SPI_CLK,
    input  logic  rst,
    input  logic  load_done,
    input  logic  unload_done,
    output mode_t mode,
    output step_t step,
    output logic  busy,
    output logic  frame_ready,
    output addr_t eng_addr_a,
    output logic  eng_we_a,
    output addr_t addr_b
);

    addr_t pix;
    logic  last_col;
    logic  first_col;
    logic  last_row;
    logic  pass_end;
    addr_t addr_e;
    addr_t addr_sw;
    addr_t addr_s;
    addr_t addr_se;

    assign pass_end = (step == STEP_SOUTHEAST) && (pix == addr_t'(PIX_N - 1));

    // load -> dither -> unload -> load
    always_ff @(posedge SPI_CLK or posedge rst) begin
        if (rst) begin
            mode <= MODE_LOAD;
        end else begin
            case (mode)
                MODE_LOAD:   if (load_done) mode <= MODE_DITHER;
                MODE_DITHER: if (pass_end) mode <= MODE_UNLOAD;
                MODE_UNLOAD: if (unload_done) mode <= MODE_LOAD;
                default:     mode <= MODE_LOAD;
            endcase
        end
    end

    // step walk, southeast wraps to quantize of the next pixel
    always_ff @(posedge SPI_CLK or posedge rst) begin
        if (rst) begin
            step <= STEP_READ_OLD;
            pix  <= '0;
        end else if (mode != MODE_DITHER || pass_end) begin
            step <= STEP_READ_OLD;
            pix  <= '0;
        end else begin
            case (step)
                STEP_READ_OLD:  step <= STEP_QUANTIZE;
                STEP_QUANTIZE:  step <= STEP_EAST;
                STEP_EAST:      step <= STEP_SOUTHWEST;
                STEP_SOUTHWEST: step <= STEP_SOUTH;
                STEP_SOUTH:     step <= STEP_SOUTHEAST;
                default: begin
                    step <= STEP_QUANTIZE;
                    pix  <= pix + addr_t'(1);
                end
            endcase
        end
    end

    assign busy        = (mode == MODE_DITHER);
    assign frame_ready = (mode == MODE_UNLOAD);

    // frame edges, neighbors off the frame are never written
    assign last_col  = ((pix % IMG_W) == IMG_W - 1);
    assign first_col = ((pix % IMG_W) == 0);
    assign last_row  = ((pix / IMG_W) == IMG_H - 1);

    // neighbor addresses wrap harmlessly on the edges
    assign addr_e  = addr_t'(pix + 1);
    assign addr_sw = addr_t'(pix + IMG_W - 1);
    assign addr_s  = addr_t'(pix + IMG_W);
    assign addr_se = addr_t'(pix + IMG_W + 1);

    // port B reads one step ahead of the port A write
    always_comb begin
        eng_addr_a = pix;
        eng_we_a   = 1'b0;
        addr_b     = pix;
        case (step)
            STEP_QUANTIZE: begin
                eng_we_a = busy;
                addr_b   = addr_e;
            end
            STEP_EAST: begin
                eng_addr_a = addr_e;
                eng_we_a   = busy && !last_col;
                addr_b     = addr_sw;
            end
            STEP_SOUTHWEST: begin
                eng_addr_a = addr_sw;
                eng_we_a   = busy && !first_col && !last_row;
                addr_b     = addr_s;
            end
            STEP_SOUTH: begin
                eng_addr_a = addr_s;
                eng_we_a   = busy && !last_row;
                addr_b     = addr_se;
            end
            STEP_SOUTHEAST: begin
                eng_addr_a = addr_se;
                eng_we_a   = busy && !last_col && !last_row;
                // old value of the next pixel
                addr_b     = addr_e;
            end
            default: ;
        endcase
    end

endmodule

/* src/spi_byte_port.sv */
//########################################
// SPI mode 0 slave byte port
// loads the frame and shifts it back out
//########################################
`timescale 1ns/100ps

module spi_byte_port import dither_pkg::*; (
    input  logic   SPI_CLK,
    input  logic   rst,
    input  logic   spi_cs,
    input  logic   spi_mosi,
    output logic   spi_miso,
    input  mode_t  mode,
    input  pixel_t q_a,
    output addr_t  spi_addr,
    output pixel_t spi_wdata,
    output logic   spi_we,
    output logic   load_done,
    output logic   unload_done
);

    logic [2:0] bit_cnt;
    pixel_t     rx_shift;
    pixel_t     tx_shift;
    addr_t      load_cnt;
    addr_t      unload_cnt;
    // readback prefetch, 2 means primed
    logic [1:0] pf_cnt;
    logic       load_active;
    logic       unload_active;
    logic       shift_en;

    assign load_active   = (mode == MODE_LOAD);
    assign unload_active = (mode == MODE_UNLOAD) && (pf_cnt == 2'd2);
    assign shift_en      = !spi_cs && (load_active || unload_active);

    // bit position, restarts whenever cs is high
    always_ff @(posedge SPI_CLK or posedge rst) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (!shift_en) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    // msb first capture
    always_ff @(posedge SPI_CLK) begin
        if (!spi_cs && load_active) begin
            rx_shift <= {rx_shift[PIX_W-2:0], spi_mosi};
        end
    end

    // write strobe one cycle after bit 8
    always_ff @(posedge SPI_CLK or posedge rst) begin
        if (rst) begin
            spi_we   <= 1'b0;
            load_cnt <= '0;
        end else begin
            spi_we <= shift_en && load_active && (bit_cnt == 3'd7);
            if (!load_active) begin
                load_cnt <= '0;
            end else if (spi_we) begin
                load_cnt <= load_cnt + addr_t'(1);
            end
        end
    end

    assign spi_wdata = rx_shift;
    assign load_done = spi_we && (load_cnt == addr_t'(PIX_N - 1));

    // readback side
    // unload_cnt runs one byte ahead of tx_shift so q_a is ready at bit 8
    always_ff @(posedge SPI_CLK or posedge rst) begin
        if (rst) begin
            pf_cnt      <= '0;
            unload_cnt  <= '0;
            tx_shift    <= '0;
            unload_done <= 1'b0;
        end else if (mode != MODE_UNLOAD) begin
            pf_cnt      <= '0;
            unload_cnt  <= '0;
            tx_shift    <= '0;
            unload_done <= 1'b0;
        end else begin
            unload_done <= shift_en && (bit_cnt == 3'd7) && (unload_cnt == '0);
            if (pf_cnt != 2'd2) begin
                pf_cnt <= pf_cnt + 2'd1;
            end
            if (pf_cnt == 2'd1) begin
                // pixel 0 arrives from the first registered read
                tx_shift   <= q_a;
                unload_cnt <= unload_cnt + addr_t'(1);
            end else if (shift_en) begin
                if (bit_cnt == 3'd7) begin
                    tx_shift   <= q_a;
                    unload_cnt <= unload_cnt + addr_t'(1);
                end else begin
                    tx_shift <= {tx_shift[PIX_W-2:0], 1'b0};
                end
            end
        end
    end

    assign spi_addr = (mode == MODE_UNLOAD) ? unload_cnt : load_cnt;
    assign spi_miso = tx_shift[PIX_W-1];

endmodule

/* src/frame_buffer.sv */
//########################################
// dual-port pixel RAM of the frame
// port A shared between SPI and engine
//########################################
`timescale 1ns/100ps

module frame_buffer import dither_pkg::*; (
    input  logic   SPI_CLK,
    input  mode_t  mode,
    // SPI side of port A
    input  addr_t  spi_addr,
    input  pixel_t spi_wdata,
    input  logic   spi_we,
    // engine side of port A
    input  addr_t  eng_addr_a,
    input  pixel_t eng_wdata_a,
    input  logic   eng_we_a,
    // port B is read only
    input  addr_t  addr_b,
    output pixel_t q_a,
    output pixel_t q_b
);

    pixel_t mem [PIX_N];

    addr_t  addr_a;
    pixel_t wdata_a;
    logic   we_a;

    // engine owns port A only during the pass
    always_comb begin
        if (mode == MODE_DITHER) begin
            addr_a  = eng_addr_a;
            wdata_a = eng_wdata_a;
            we_a    = eng_we_a;
        end else begin
            addr_a  = spi_addr;
            wdata_a = spi_wdata;
            we_a    = spi_we;
        end
    end

    // registered reads, old data on a colliding write
    always_ff @(posedge SPI_CLK) begin
        if (we_a) begin
            mem[addr_a] <= wdata_a;
        end
        q_a <= mem[addr_a];
        q_b <= mem[addr_b];
    end

endmodule

/* src/dither_pkg.sv */
//########################################
// halftoning engine shared definitions
// frame geometry and pixel arithmetic
//########################################

package dither_pkg;

    // frame geometry
    localparam int IMG_W  = 8;
    localparam int IMG_H  = 8;
    localparam int PIX_N  = IMG_W * IMG_H;
    localparam int PIX_W  = 8;
    localparam int ADDR_W = $clog2(PIX_N);

    // quantizer
    localparam int THRESHOLD = 128;
    localparam int PIX_MAX   = 255;

    // floyd-steinberg weights in sixteenths
    localparam int W_EAST      = 7;
    localparam int W_SOUTHWEST = 3;
    localparam int W_SOUTH     = 5;
    localparam int W_SOUTHEAST = 1;

    typedef logic [PIX_W-1:0]         pixel_t;
    typedef logic [ADDR_W-1:0]        addr_t;
    // old minus new, fits -255..255
    typedef logic signed [PIX_W:0]    qerr_t;

    typedef enum logic [1:0] {
        MODE_LOAD,
        MODE_DITHER,
        MODE_UNLOAD
    } mode_t;

    // per-pixel schedule of the dither pass
    typedef enum logic [2:0] {
        STEP_READ_OLD,
        STEP_QUANTIZE,
        STEP_EAST,
        STEP_SOUTHWEST,
        STEP_SOUTH,
        STEP_SOUTHEAST
    } step_t;

endpackage
